// File: include/axi_consts.svh
// Channel widths, slave count and address map bounds for the AXI read crossbar
`ifndef AXI_CONSTS_SVH
`define AXI_CONSTS_SVH

// ******************************
// Channel field widths
// ******************************
`define AXI_ID_BITS    4
`define AXI_ADDR_BITS  32
`define AXI_LEN_BITS   8
`define AXI_DATA_BITS  32

// Number of slaves behind the crossbar
`define AXI_NUM_SLAVES 4

// ******************************
// Address map, inclusive bounds
// ******************************
// ROM
`define REGION0_START  32'h0000_0000
`define REGION0_END    32'h0000_3FFF
// Instruction memory
`define REGION1_START  32'h0001_0000
`define REGION1_END    32'h0001_FFFF
// Data memory
`define REGION2_START  32'h0002_0000
`define REGION2_END    32'h0002_FFFF
// DRAM
`define REGION3_START  32'h2000_0000
`define REGION3_END    32'h207F_FFFF

`endif

// File: hw/axi_chan_pkg.sv
// AXI read channel field types and response codes
`include "axi_consts.svh"

package axi_chan_pkg;

  // Transaction ID
  typedef logic [`AXI_ID_BITS-1:0]   axi_id_t;

  // Byte address
  typedef logic [`AXI_ADDR_BITS-1:0] axi_addr_t;

  // Burst length, beats minus one
  typedef logic [`AXI_LEN_BITS-1:0]  axi_len_t;

  // One data beat
  typedef logic [`AXI_DATA_BITS-1:0] axi_data_t;

  // Read response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } axi_resp_t;

endpackage

// File: hw/axi_map_pkg.sv
// Slave selection types and helpers for the crossbar address map
`include "axi_consts.svh"

package axi_map_pkg;

  // One-hot choice of a slave, bit n selects slave n
  typedef logic [`AXI_NUM_SLAVES-1:0] slave_sel_t;

  // Binary slave number
  typedef logic [$clog2(`AXI_NUM_SLAVES)-1:0] slave_idx_t;

  // Empty selection, nothing routed
  localparam slave_sel_t SEL_NONE = '0;

  // Expand a slave number into its one-hot select
  function automatic slave_sel_t sel_from_idx(slave_idx_t idx);
    slave_sel_t sel;
    sel      = SEL_NONE;
    sel[idx] = 1'b1;
    return sel;
  endfunction

endpackage

// File: hw/axi_read_decoder.sv
// Read address acceptance, region decode and request holding registers
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_read_decoder (
  input  logic                    axi_clk,
  input  logic                    axi_rst,
  input  logic                    ar_valid_i,
  input  axi_chan_pkg::axi_id_t   ar_id_i,
  input  axi_chan_pkg::axi_addr_t ar_addr_i,
  input  axi_chan_pkg::axi_len_t  ar_len_i,
  output logic                    ar_ready_o,
  input  logic                    done_i,
  output axi_map_pkg::slave_sel_t start_o,
  output logic                    err_start_o,
  output axi_chan_pkg::axi_id_t   req_id_o,
  output axi_chan_pkg::axi_addr_t req_addr_o,
  output axi_chan_pkg::axi_len_t  req_len_o
);
  import axi_chan_pkg::*;
  import axi_map_pkg::*;

  // Region bounds indexed by slave number
  localparam axi_addr_t REGION_LO [`AXI_NUM_SLAVES] = '{
    `REGION0_START, `REGION1_START, `REGION2_START, `REGION3_START
  };
  localparam axi_addr_t REGION_HI [`AXI_NUM_SLAVES] = '{
    `REGION0_END, `REGION1_END, `REGION2_END, `REGION3_END
  };

  logic       busy;
  logic       ar_fire;
  logic       hit;
  slave_idx_t hit_idx;

  // One read in flight, so the address channel opens only when idle
  assign ar_ready_o = ~busy;
  assign ar_fire    = ar_valid_i & ~busy;

  // First matching region wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < `AXI_NUM_SLAVES; i++) begin
      if (!hit && (ar_addr_i >= REGION_LO[i]) && (ar_addr_i <= REGION_HI[i])) begin
        hit     = 1'b1;
        hit_idx = slave_idx_t'(i);
      end
    end
  end

  // Busy flag and single-cycle launch strobes
  always_ff @(posedge axi_clk or posedge axi_rst) begin
    if (axi_rst) begin
      busy        <= 1'b0;
      start_o     <= SEL_NONE;
      err_start_o <= 1'b0;
    end else begin
      start_o     <= SEL_NONE;
      err_start_o <= 1'b0;
      if (ar_fire) begin
        busy        <= 1'b1;
        start_o     <= hit ? sel_from_idx(hit_idx) : SEL_NONE;
        err_start_o <= ~hit;
      end else if (done_i) begin
        busy <= 1'b0;
      end
    end
  end

  // Request fields held for the whole transaction
  always_ff @(posedge axi_clk) begin
    if (ar_fire) begin
      req_id_o   <= ar_id_i;
      req_addr_o <= ar_addr_i;
      req_len_o  <= ar_len_i;
    end
  end

endmodule

// File: hw/axi_slave_port.sv
// Per-slave stage driving the slave AR channel and gating its read beats
`timescale 1ns/1ps

module axi_slave_port (
  input  logic                    axi_clk,
  input  logic                    axi_rst,
  input  logic                    start_i,
  input  logic                    done_i,
  input  axi_chan_pkg::axi_id_t   req_id_i,
  input  axi_chan_pkg::axi_addr_t req_addr_i,
  input  axi_chan_pkg::axi_len_t  req_len_i,
  // Slave side
  output logic                    s_ar_valid_o,
  output axi_chan_pkg::axi_id_t   s_ar_id_o,
  output axi_chan_pkg::axi_addr_t s_ar_addr_o,
  output axi_chan_pkg::axi_len_t  s_ar_len_o,
  input  logic                    s_ar_ready_i,
  input  logic                    s_r_valid_i,
  input  axi_chan_pkg::axi_id_t   s_r_id_i,
  input  axi_chan_pkg::axi_data_t s_r_data_i,
  input  axi_chan_pkg::axi_resp_t s_r_resp_i,
  input  logic                    s_r_last_i,
  output logic                    s_r_ready_o,
  // Lane toward the return stage
  output logic                    p_r_valid_o,
  output axi_chan_pkg::axi_id_t   p_r_id_o,
  output axi_chan_pkg::axi_data_t p_r_data_o,
  output axi_chan_pkg::axi_resp_t p_r_resp_o,
  output logic                    p_r_last_o,
  input  logic                    p_r_ready_i
);
  import axi_chan_pkg::*;

  logic addr_pend;
  logic active;

  // ******************************
  // Address phase
  // ******************************
  always_ff @(posedge axi_clk or posedge axi_rst) begin
    if (axi_rst) begin
      addr_pend <= 1'b0;
      active    <= 1'b0;
    end else if (start_i) begin
      // Slave may already accept in the strobe cycle
      addr_pend <= ~s_ar_ready_i;
      active    <= 1'b1;
    end else begin
      if (addr_pend && s_ar_ready_i) begin
        addr_pend <= 1'b0;
      end
      // Completion is broadcast, only the active port reacts
      if (done_i) begin
        active <= 1'b0;
      end
    end
  end

  // Address valid opens together with the launch strobe
  assign s_ar_valid_o = start_i | addr_pend;
  assign s_ar_id_o    = req_id_i;
  assign s_ar_addr_o  = req_addr_i;
  assign s_ar_len_o   = req_len_i;

  // ******************************
  // Data phase
  // ******************************
  // Idle lanes drive zeros so the return stage can OR them together
  assign p_r_valid_o = active & s_r_valid_i;
  assign p_r_id_o    = active ? s_r_id_i : '0;
  assign p_r_data_o  = active ? s_r_data_i : '0;
  assign p_r_resp_o  = active ? s_r_resp_i : OKAY;
  assign p_r_last_o  = active & s_r_last_i;

  // Master back-pressure reaches the slave in the same cycle
  assign s_r_ready_o = active & p_r_ready_i;

endmodule

// File: hw/axi_read_return.sv
// Read data merge, decode-error burst generation and completion strobe
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_read_return (
  input  logic                                         axi_clk,
  input  logic                                         axi_rst,
  input  logic                                         err_start_i,
  input  axi_chan_pkg::axi_id_t                        req_id_i,
  input  axi_chan_pkg::axi_len_t                       req_len_i,
  // Port lanes, one per slave
  input  logic                    [`AXI_NUM_SLAVES-1:0] p_r_valid_i,
  input  axi_chan_pkg::axi_id_t   [`AXI_NUM_SLAVES-1:0] p_r_id_i,
  input  axi_chan_pkg::axi_data_t [`AXI_NUM_SLAVES-1:0] p_r_data_i,
  input  axi_chan_pkg::axi_resp_t [`AXI_NUM_SLAVES-1:0] p_r_resp_i,
  input  logic                    [`AXI_NUM_SLAVES-1:0] p_r_last_i,
  output logic                                         p_r_ready_o,
  // Master R channel
  output logic                                         r_valid_o,
  output axi_chan_pkg::axi_id_t                        r_id_o,
  output axi_chan_pkg::axi_data_t                      r_data_o,
  output axi_chan_pkg::axi_resp_t                      r_resp_o,
  output logic                                         r_last_o,
  input  logic                                         r_ready_i,
  output logic                                         done_o
);
  import axi_chan_pkg::*;

  logic       err_busy;
  logic       err_valid;
  logic       err_last;
  axi_len_t   beat_cnt;
  logic       valid_or;
  axi_id_t    id_or;
  axi_data_t  data_or;
  logic [1:0] resp_or;
  logic       last_or;

  // Error burst starts beating in the same cycle as its strobe
  assign err_valid = err_start_i | err_busy;
  assign err_last  = (beat_cnt == req_len_i);

  always_ff @(posedge axi_clk or posedge axi_rst) begin
    if (axi_rst) begin
      err_busy <= 1'b0;
      beat_cnt <= '0;
    end else begin
      if (err_start_i) begin
        err_busy <= 1'b1;
      end
      if (err_valid && r_ready_i) begin
        if (err_last) begin
          err_busy <= 1'b0;
          beat_cnt <= '0;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  // ******************************
  // Merge onto the master channel
  // ******************************
  always_comb begin
    valid_or = 1'b0;
    id_or    = '0;
    data_or  = '0;
    resp_or  = '0;
    last_or  = 1'b0;
    for (int i = 0; i < `AXI_NUM_SLAVES; i++) begin
      valid_or = valid_or | p_r_valid_i[i];
      id_or    = id_or | p_r_id_i[i];
      data_or  = data_or | p_r_data_i[i];
      resp_or  = resp_or | p_r_resp_i[i];
      last_or  = last_or | p_r_last_i[i];
    end
  end

  // Error beats carry zero data and the held ID
  assign r_valid_o = valid_or | err_valid;
  assign r_id_o    = err_valid ? req_id_i : id_or;
  assign r_data_o  = err_valid ? '0 : data_or;
  assign r_resp_o  = err_valid ? DECERR : axi_resp_t'(resp_or);
  assign r_last_o  = err_valid ? err_last : last_or;

  assign p_r_ready_o = r_ready_i;

  // Last beat accepted by the master ends the transaction
  assign done_o = r_valid_o & r_ready_i & r_last_o;

endmodule

// File: hw/axi_read_xbar.sv
// Top level of the single-master AXI read crossbar over four slaves
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_read_xbar (
  input  logic                                         axi_clk,
  input  logic                                         axi_rst,
  // Master AR and R channels
  input  logic                                         ar_valid_i,
  input  axi_chan_pkg::axi_id_t                        ar_id_i,
  input  axi_chan_pkg::axi_addr_t                      ar_addr_i,
  input  axi_chan_pkg::axi_len_t                       ar_len_i,
  output logic                                         ar_ready_o,
  output logic                                         r_valid_o,
  output axi_chan_pkg::axi_id_t                        r_id_o,
  output axi_chan_pkg::axi_data_t                      r_data_o,
  output axi_chan_pkg::axi_resp_t                      r_resp_o,
  output logic                                         r_last_o,
  input  logic                                         r_ready_i,
  // Slave AR and R channels, indexed by slave number
  output logic                    [`AXI_NUM_SLAVES-1:0] s_ar_valid_o,
  output axi_chan_pkg::axi_id_t   [`AXI_NUM_SLAVES-1:0] s_ar_id_o,
  output axi_chan_pkg::axi_addr_t [`AXI_NUM_SLAVES-1:0] s_ar_addr_o,
  output axi_chan_pkg::axi_len_t  [`AXI_NUM_SLAVES-1:0] s_ar_len_o,
  input  logic                    [`AXI_NUM_SLAVES-1:0] s_ar_ready_i,
  input  logic                    [`AXI_NUM_SLAVES-1:0] s_r_valid_i,
  input  axi_chan_pkg::axi_id_t   [`AXI_NUM_SLAVES-1:0] s_r_id_i,
  input  axi_chan_pkg::axi_data_t [`AXI_NUM_SLAVES-1:0] s_r_data_i,
  input  axi_chan_pkg::axi_resp_t [`AXI_NUM_SLAVES-1:0] s_r_resp_i,
  input  logic                    [`AXI_NUM_SLAVES-1:0] s_r_last_i,
  output logic                    [`AXI_NUM_SLAVES-1:0] s_r_ready_o
);
  import axi_chan_pkg::*;
  import axi_map_pkg::*;

  // Launch and completion strobes
  slave_sel_t start;
  logic       err_start;
  logic       done;

  // Held request
  axi_id_t    req_id;
  axi_addr_t  req_addr;
  axi_len_t   req_len;

  // Port lanes toward the return stage
  logic      [`AXI_NUM_SLAVES-1:0] p_r_valid;
  axi_id_t   [`AXI_NUM_SLAVES-1:0] p_r_id;
  axi_data_t [`AXI_NUM_SLAVES-1:0] p_r_data;
  axi_resp_t [`AXI_NUM_SLAVES-1:0] p_r_resp;
  logic      [`AXI_NUM_SLAVES-1:0] p_r_last;
  logic                            p_r_ready;

  axi_read_decoder u_decoder (
    .axi_clk     (axi_clk),
    .axi_rst     (axi_rst),
    .ar_valid_i  (ar_valid_i),
    .ar_id_i     (ar_id_i),
    .ar_addr_i   (ar_addr_i),
    .ar_len_i    (ar_len_i),
    .ar_ready_o  (ar_ready_o),
    .done_i      (done),
    .start_o     (start),
    .err_start_o (err_start),
    .req_id_o    (req_id),
    .req_addr_o  (req_addr),
    .req_len_o   (req_len)
  );

  // ******************************
  // One port stage per slave
  // ******************************
  for (genvar g = 0; g < `AXI_NUM_SLAVES; g++) begin : g_port
    axi_slave_port u_port (
      .axi_clk      (axi_clk),
      .axi_rst      (axi_rst),
      .start_i      (start[g]),
      .done_i       (done),
      .req_id_i     (req_id),
      .req_addr_i   (req_addr),
      .req_len_i    (req_len),
      .s_ar_valid_o (s_ar_valid_o[g]),
      .s_ar_id_o    (s_ar_id_o[g]),
      .s_ar_addr_o  (s_ar_addr_o[g]),
      .s_ar_len_o   (s_ar_len_o[g]),
      .s_ar_ready_i (s_ar_ready_i[g]),
      .s_r_valid_i  (s_r_valid_i[g]),
      .s_r_id_i     (s_r_id_i[g]),
      .s_r_data_i   (s_r_data_i[g]),
      .s_r_resp_i   (s_r_resp_i[g]),
      .s_r_last_i   (s_r_last_i[g]),
      .s_r_ready_o  (s_r_ready_o[g]),
      .p_r_valid_o  (p_r_valid[g]),
      .p_r_id_o     (p_r_id[g]),
      .p_r_data_o   (p_r_data[g]),
      .p_r_resp_o   (p_r_resp[g]),
      .p_r_last_o   (p_r_last[g]),
      .p_r_ready_i  (p_r_ready)
    );
  end

  axi_read_return u_return (
    .axi_clk     (axi_clk),
    .axi_rst     (axi_rst),
    .err_start_i (err_start),
    .req_id_i    (req_id),
    .req_len_i   (req_len),
    .p_r_valid_i (p_r_valid),
    .p_r_id_i    (p_r_id),
    .p_r_data_i  (p_r_data),
    .p_r_resp_i  (p_r_resp),
    .p_r_last_i  (p_r_last),
    .p_r_ready_o (p_r_ready),
    .r_valid_o   (r_valid_o),
    .r_id_o      (r_id_o),
    .r_data_o    (r_data_o),
    .r_resp_o    (r_resp_o),
    .r_last_o    (r_last_o),
    .r_ready_i   (r_ready_i),
    .done_o      (done)
  );

endmodule

// File: testbench/axi_read_xbar_assertions.sv
// Concurrent protocol assertions for the AXI read crossbar, bound to its top level
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_read_xbar_assertions (
  input logic                       axi_clk,
  input logic                       axi_rst,
  input logic                       ar_valid_i,
  input logic                       ar_ready_i,
  input logic                       done_i,
  input logic                       r_valid_i,
  input logic                       r_ready_i,
  input logic [`AXI_NUM_SLAVES-1:0] s_ar_valid_i,
  input logic [`AXI_NUM_SLAVES-1:0] s_ar_ready_i
);

  // ******************************
  // Valid holds until its handshake
  // ******************************
  assert property (@(posedge axi_clk) disable iff (axi_rst)
    (ar_valid_i && !ar_ready_i) |=> ar_valid_i)
    else $error("ar_valid dropped before its handshake");

  assert property (@(posedge axi_clk) disable iff (axi_rst)
    (r_valid_i && !r_ready_i) |=> r_valid_i)
    else $error("r_valid dropped before its handshake");

  for (genvar k = 0; k < `AXI_NUM_SLAVES; k++) begin : g_sar
    assert property (@(posedge axi_clk) disable iff (axi_rst)
      (s_ar_valid_i[k] && !s_ar_ready_i[k]) |=> s_ar_valid_i[k])
      else $error("s_ar_valid of slave %0d dropped before its handshake", k);
  end

  // One slave addressed at a time
  assert property (@(posedge axi_clk) disable iff (axi_rst) $onehot0(s_ar_valid_i))
    else $error("More than one slave sees an address valid");

  // No read data right out of reset
  assert property (@(posedge axi_clk) $fell(axi_rst) |-> !r_valid_i)
    else $error("r_valid high in the first cycle after reset");

  // Address channel closed from acceptance until done
  assert property (@(posedge axi_clk) disable iff (axi_rst)
    (ar_valid_i && ar_ready_i) |=> !ar_ready_i)
    else $error("ar_ready still high after an accepted read");

  assert property (@(posedge axi_clk) disable iff (axi_rst)
    (!ar_ready_i && !done_i) |=> !ar_ready_i)
    else $error("ar_ready rose before the read was done");

endmodule

// File: testbench/axi_read_checker.sv
// Master R channel monitor that compares every beat with queued expected beats
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_read_checker (
  input logic                    axi_clk,
  input logic                    axi_rst,
  input logic                    r_valid_i,
  input logic                    r_ready_i,
  input axi_chan_pkg::axi_id_t   r_id_i,
  input axi_chan_pkg::axi_data_t r_data_i,
  input axi_chan_pkg::axi_resp_t r_resp_i,
  input logic                    r_last_i
);

  // Beat word is {id, resp, last, data}
  localparam int BEAT_BITS = `AXI_ID_BITS + 2 + 1 + `AXI_DATA_BITS;

  logic [BEAT_BITS-1:0] exp_q [$];
  string                name_q [$];
  int                   pending = 0;
  int                   mismatch_cnt = 0;
  int                   unexpected_cnt = 0;

  // Queue one expected beat together with the name of its test
  task automatic expect_beat(input string name, input logic [BEAT_BITS-1:0] word);
    exp_q.push_back(word);
    name_q.push_back(name);
    pending = pending + 1;
  endtask

  // ******************************
  // Compare on every R handshake
  // ******************************
  always @(posedge axi_clk) begin
    logic [BEAT_BITS-1:0] act;
    logic [BEAT_BITS-1:0] exp_word;
    string                name;
    if (!axi_rst && r_valid_i && r_ready_i) begin
      act = {r_id_i, r_resp_i, r_last_i, r_data_i};
      if (pending == 0) begin
        unexpected_cnt++;
        $display("Read beat with no outstanding request, id %h data %h", r_id_i, r_data_i);
      end else begin
        exp_word = exp_q.pop_front();
        name     = name_q.pop_front();
        pending  = pending - 1;
        // Fields in the printed words are id, resp, last, data
        if (act !== exp_word) begin
          mismatch_cnt++;
          $display("Mismatch %s: expected %h, actual %h", name, exp_word, act);
        end
      end
    end
  end

endmodule

// File: testbench/axi_read_xbar_tb.sv
// Testbench top for the AXI read crossbar with master driver, slave model and reference model
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi_read_xbar_tb;
  import axi_chan_pkg::*;

  localparam int NS        = `AXI_NUM_SLAVES;
  localparam int BEAT_BITS = `AXI_ID_BITS + 2 + 1 + `AXI_DATA_BITS;
  localparam int TIMEOUT   = 2000;

  // Address map, inclusive bounds
  localparam axi_addr_t REG_LO [NS] = '{
    `REGION0_START, `REGION1_START, `REGION2_START, `REGION3_START
  };
  localparam axi_addr_t REG_HI [NS] = '{
    `REGION0_END, `REGION1_END, `REGION2_END, `REGION3_END
  };

  logic      axi_clk = 1'b0;
  logic      axi_rst;
  logic      ar_valid_i;
  axi_id_t   ar_id_i;
  axi_addr_t ar_addr_i;
  axi_len_t  ar_len_i;
  logic      ar_ready_o;
  logic      r_valid_o;
  axi_id_t   r_id_o;
  axi_data_t r_data_o;
  axi_resp_t r_resp_o;
  logic      r_last_o;
  logic      r_ready_i = 1'b0;
  logic      [NS-1:0] s_ar_valid_o;
  axi_id_t   [NS-1:0] s_ar_id_o;
  axi_addr_t [NS-1:0] s_ar_addr_o;
  axi_len_t  [NS-1:0] s_ar_len_o;
  logic      [NS-1:0] s_ar_ready_i;
  logic      [NS-1:0] s_r_valid_i;
  axi_id_t   [NS-1:0] s_r_id_i;
  axi_data_t [NS-1:0] s_r_data_i;
  axi_resp_t [NS-1:0] s_r_resp_i;
  logic      [NS-1:0] s_r_last_i;
  logic      [NS-1:0] s_r_ready_o;

  // Request in flight, as the slave model should see it
  string     test_name = "";
  int        exp_slave = -1;
  axi_id_t   exp_id;
  axi_addr_t exp_addr;
  axi_len_t  exp_len;

  int   seed = 18480;
  int   other_errs = 0;
  logic backpressure = 1'b0;

  axi_read_xbar UUT (.*);

  axi_read_checker u_checker (
    .axi_clk   (axi_clk),
    .axi_rst   (axi_rst),
    .r_valid_i (r_valid_o),
    .r_ready_i (r_ready_i),
    .r_id_i    (r_id_o),
    .r_data_i  (r_data_o),
    .r_resp_i  (r_resp_o),
    .r_last_i  (r_last_o)
  );

  bind axi_read_xbar axi_read_xbar_assertions u_assertions (
    .axi_clk      (axi_clk),
    .axi_rst      (axi_rst),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_i   (ar_ready_o),
    .done_i       (done),
    .r_valid_i    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .s_ar_valid_i (s_ar_valid_o),
    .s_ar_ready_i (s_ar_ready_i)
  );

  always #5 axi_clk = ~axi_clk;

  // Master ready, random when back-pressure is on
  always @(negedge axi_clk) begin
    if (backpressure) begin
      r_ready_i = ({$random(seed)} % 4) != 0;
    end else begin
      r_ready_i = 1'b1;
    end
  end

  // ******************************
  // Reference model
  // ******************************
  function automatic int region_of(input axi_addr_t addr);
    int k;
    for (k = 0; k < NS; k++) begin
      if (addr >= REG_LO[k] && addr <= REG_HI[k]) begin
        return k;
      end
    end
    return -1;
  endfunction

  // Expected {id, resp, last, data} of beat b
  function automatic logic [BEAT_BITS-1:0] ref_beat(input axi_addr_t addr, input axi_len_t len,
                                                    input axi_id_t id, input int b);
    int        slave;
    axi_addr_t beat_addr;
    axi_data_t data;
    axi_resp_t resp;
    slave     = region_of(addr);
    beat_addr = addr + axi_addr_t'(4 * b);
    data      = '0;
    resp      = DECERR;
    if (slave >= 0) begin
      data = {slave[7:0], beat_addr[23:0]};
      resp = OKAY;
    end
    return {id, resp, b == int'(len), data};
  endfunction

  // Word address inside region r, anywhere when r is past the last region
  function automatic axi_addr_t pick_addr(input int r);
    axi_addr_t offset;
    if (r >= NS) begin
      return {$random(seed)} & ~32'h3;
    end
    offset = {$random(seed)} % (REG_HI[r] - REG_LO[r] + 1);
    return (REG_LO[r] + offset) & ~32'h3;
  endfunction

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s in %s", what, test_name);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  // ******************************
  // Slave model
  // ******************************
  task automatic serve_read(input int k);
    axi_id_t   id;
    axi_addr_t addr;
    axi_addr_t beat_addr;
    axi_len_t  len;
    int        b;
    int        cnt;
    id   = s_ar_id_o[k];
    addr = s_ar_addr_o[k];
    len  = s_ar_len_o[k];
    if (k != exp_slave) begin
      other_errs++;
      $display("Slave %0d received an address that was not routed to it in %s",
               k, test_name);
    end else if (id !== exp_id || addr !== exp_addr || len !== exp_len) begin
      other_errs++;
      $display("Mismatch %s: expected id %h addr %h len %0d, actual id %h addr %h len %0d",
               test_name, exp_id, exp_addr, exp_len, id, addr, len);
    end
    // Accept after 0 to 3 cycles
    repeat ({$random(seed)} % 4) @(negedge axi_clk);
    s_ar_ready_i[k] = 1'b1;
    @(negedge axi_clk);
    s_ar_ready_i[k] = 1'b0;
    for (b = 0; b <= int'(len); b++) begin
      repeat ({$random(seed)} % 3) @(negedge axi_clk);
      beat_addr      = addr + axi_addr_t'(4 * b);
      s_r_valid_i[k] = 1'b1;
      s_r_id_i[k]    = id;
      s_r_data_i[k]  = {8'(k), beat_addr[23:0]};
      s_r_resp_i[k]  = OKAY;
      s_r_last_i[k]  = (b == int'(len));
      cnt = 0;
      @(posedge axi_clk);
      while (!s_r_ready_o[k]) begin
        cnt++;
        if (cnt > TIMEOUT) report_timeout("s_r_ready_o");
        @(posedge axi_clk);
      end
      @(negedge axi_clk);
      s_r_valid_i[k] = 1'b0;
      s_r_last_i[k]  = 1'b0;
    end
  endtask

  initial begin : slave_model
    int k;
    s_ar_ready_i = '0;
    s_r_valid_i  = '0;
    s_r_id_i     = '0;
    s_r_data_i   = '0;
    s_r_last_i   = '0;
    for (k = 0; k < NS; k++) begin
      s_r_resp_i[k] = OKAY;
    end
    forever begin
      @(negedge axi_clk);
      for (k = 0; k < NS; k++) begin
        if (!axi_rst && s_ar_valid_o[k]) serve_read(k);
      end
    end
  end

  // ******************************
  // Master driver
  // ******************************
  task automatic issue_read(input string name, input axi_id_t id, input axi_addr_t addr,
                            input axi_len_t len);
    int b;
    int cnt;
    test_name = name;
    exp_slave = region_of(addr);
    exp_id    = id;
    exp_addr  = addr;
    exp_len   = len;
    for (b = 0; b <= int'(len); b++) begin
      u_checker.expect_beat(name, ref_beat(addr, len, id, b));
    end
    @(negedge axi_clk);
    ar_valid_i = 1'b1;
    ar_id_i    = id;
    ar_addr_i  = addr;
    ar_len_i   = len;
    cnt = 0;
    @(posedge axi_clk);
    while (!ar_ready_o) begin
      cnt++;
      if (cnt > TIMEOUT) report_timeout("ar_ready_o");
      @(posedge axi_clk);
    end
    @(negedge axi_clk);
    ar_valid_i = 1'b0;
    // Address channel must stay closed until the last beat
    cnt = 0;
    while (u_checker.pending != 0) begin
      if (ar_ready_o) begin
        other_errs++;
        $display("Mismatch %s: expected ar_ready_o 0 while busy, actual %b",
                 name, ar_ready_o);
      end
      cnt++;
      if (cnt > TIMEOUT) report_timeout("the last read beat");
      @(negedge axi_clk);
    end
  endtask

  initial begin : main
    int i;
    int r;
    int total;
    axi_rst    = 1'b1;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    repeat (16) @(posedge axi_clk);
    @(negedge axi_clk);
    axi_rst = 1'b0;
    @(negedge axi_clk);
    test_name = "reset";
    if (ar_ready_o !== 1'b1 || r_valid_o !== 1'b0 || s_ar_valid_o !== '0) begin
      other_errs++;
      $display("Mismatch %s: expected ar_ready/r_valid/s_ar_valid 1/0/0, actual %b/%b/%b",
               test_name, ar_ready_o, r_valid_o, s_ar_valid_o);
    end
    // Both ends of every region
    for (i = 0; i < NS; i++) begin
      issue_read($sformatf("region%0d_low", i), axi_id_t'(i), REG_LO[i], 8'd3);
      issue_read($sformatf("region%0d_high", i), axi_id_t'(i + 8), REG_HI[i] & ~32'h3, 8'd0);
    end
    issue_read("burst_1", 4'h1, 32'h0002_0100, 8'd0);
    issue_read("burst_4", 4'h2, 32'h0002_0200, 8'd3);
    issue_read("burst_16", 4'h3, 32'h2000_1000, 8'd15);
    backpressure = 1'b1;
    for (i = 0; i < NS; i++) begin
      issue_read($sformatf("backpressure%0d", i), axi_id_t'(i + 4), REG_LO[i] + 32'h40, 8'd7);
    end
    // Holes in the map
    issue_read("unmapped_after_rom", 4'h5, 32'h0000_4000, 8'd2);
    issue_read("unmapped_dram_gap", 4'h6, 32'h0003_0000, 8'd3);
    issue_read("unmapped_below_dram", 4'h7, 32'h1FFF_FFFC, 8'd0);
    issue_read("unmapped_above_dram", 4'h8, 32'h2080_0000, 8'd15);
    for (i = 0; i < 200; i++) begin
      r = {$random(seed)} % 5;
      issue_read($sformatf("random%0d", i), axi_id_t'($random(seed)), pick_addr(r),
                 axi_len_t'({$random(seed)} % 16));
    end
    repeat (4) @(negedge axi_clk);
    total = u_checker.mismatch_cnt + u_checker.unexpected_cnt + u_checker.pending + other_errs;
    $display("Errors: %0d mismatches, %0d unexpected beats, %0d missing beats, %0d other",
             u_checker.mismatch_cnt, u_checker.unexpected_cnt, u_checker.pending, other_errs);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+include
hw/axi_chan_pkg.sv
hw/axi_map_pkg.sv
hw/axi_read_decoder.sv
hw/axi_slave_port.sv
hw/axi_read_return.sv
hw/axi_read_xbar.sv
testbench/axi_read_xbar_assertions.sv
testbench/axi_read_checker.sv
testbench/axi_read_xbar_tb.sv

// File: run.sh
#!/bin/bash
# Build the AXI read crossbar testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module axi_read_xbar_tb -o axi_read_xbar_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/axi_read_xbar_sim > sim.log 2>&1
cat sim.log

grep -qF '*** TEST PASSED ***' sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
